//--- hw/perf_monitor_config.svh
`ifndef PERF_MONITOR_CONFIG_SVH
`define PERF_MONITOR_CONFIG_SVH

// data bus and counter width.
`define PERF_DATA_W 16

// data memory address width.
`define PERF_ADDR_W 16

// the monitor window starts here; this is also the control register.
`define PERF_BASE_ADDR 16'hFFE4

// counter 0 lives here and the rest follow at even addresses up to 16'hFFFE.
`define PERF_CNT_BASE_ADDR 16'hFFE6

// number of event counters.
`define PERF_NUM_CNT 13

// width of a counter index.
`define PERF_IDX_W 4

// window length field taken from write data bits 15:2.
`define PERF_WIN_W 14

`endif

//--- hw/perf_pkg.sv
`include "perf_monitor_config.svh"

package perf_pkg;

    // one-cycle event pulses declared in counter address order.
    typedef struct packed {
        logic pred_correct;
        logic pred_incorrect;
        logic icache_hit;
        logic icache_miss;
        logic dcache_hit;
        logic dcache_miss;
        logic l2_hit;
        logic l2_miss;
        logic stall_if;
        logic stall_id;
        logic stall_ex;
        logic stall_mem;
        logic stall_wb;
    } perf_events_t;

    // data memory port as seen by the monitor.
    typedef struct packed {
        logic                    access;
        logic                    we;
        logic [`PERF_ADDR_W-1:0] addr;
        logic [`PERF_DATA_W-1:0] wdata;
    } perf_bus_req_t;

    // one cycle worth of decoded access.
    typedef struct packed {
        logic                   hit;
        logic                   rd_valid;
        logic [`PERF_IDX_W-1:0] rd_idx;
        logic                   rd_ctrl;
        logic                   clr_valid;
        logic [`PERF_IDX_W-1:0] clr_idx;
        logic                   ctrl_wr;
    } perf_decode_t;

    typedef enum logic [1:0] {
        ST_HALTED = 2'd0,
        ST_RUN    = 2'd1,
        ST_WINDOW = 2'd2
    } perf_state_e;

    // command field in write data bits 1:0; the value 3 does nothing.
    typedef enum logic [1:0] {
        CMD_HALT   = 2'd0,
        CMD_RUN    = 2'd1,
        CMD_WINDOW = 2'd2
    } perf_cmd_e;

endpackage

//--- hw/perf_addr_decode.sv
`timescale 1ns/1ps
`include "perf_monitor_config.svh"

module perf_addr_decode (
    input  perf_pkg::perf_bus_req_t i_req,
    output perf_pkg::perf_decode_t  o_dec
);

    logic                    in_window;
    logic                    is_ctrl;
    logic                    is_cnt;
    logic [`PERF_ADDR_W-1:0] cnt_offset;
    logic [`PERF_ADDR_W-1:0] cnt_slot;
    logic [`PERF_IDX_W-1:0]  cnt_idx;

    // anything at or above the base address belongs to the monitor.
    assign in_window = i_req.access && (i_req.addr >= `PERF_BASE_ADDR);

    // byte offset from counter 0 with two bytes per counter.
    assign cnt_offset = i_req.addr - `PERF_CNT_BASE_ADDR;
    assign cnt_slot   = cnt_offset >> 1;
    assign cnt_idx    = cnt_offset[`PERF_IDX_W:1];

    assign is_ctrl = in_window && (i_req.addr == `PERF_BASE_ADDR);

    // odd offsets and slots past the last counter decode to nothing.
    assign is_cnt = in_window
                 && (i_req.addr >= `PERF_CNT_BASE_ADDR)
                 && !cnt_offset[0]
                 && (cnt_slot < `PERF_ADDR_W'(`PERF_NUM_CNT));

    always_comb begin
        o_dec = '0;
        o_dec.hit = in_window;

        if (is_cnt && !i_req.we) begin
            o_dec.rd_valid = 1'b1;
            o_dec.rd_idx   = cnt_idx;
        end

        // a store to a counter address clears that counter.
        if (is_cnt && i_req.we) begin
            o_dec.clr_valid = 1'b1;
            o_dec.clr_idx   = cnt_idx;
        end

        o_dec.rd_ctrl = is_ctrl && !i_req.we;
        o_dec.ctrl_wr = is_ctrl && i_req.we;
    end

endmodule

//--- hw/perf_ctrl_fsm.sv
`timescale 1ns/1ps
`include "perf_monitor_config.svh"

module perf_ctrl_fsm (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_ctrl_wr,
    input  logic [`PERF_DATA_W-1:0] i_wdata,
    input  logic                    i_expire,
    output perf_pkg::perf_state_e   o_state,
    output logic                    o_count_en,
    output logic                    o_timer_load,
    output logic [`PERF_WIN_W-1:0]  o_timer_len
);

    perf_pkg::perf_state_e  state_q;
    perf_pkg::perf_state_e  state_d;
    logic [1:0]             cmd;
    logic [`PERF_WIN_W-1:0] win_len;
    logic                   cmd_taken;

    assign cmd     = i_wdata[1:0];
    assign win_len = i_wdata[`PERF_DATA_W-1:2];

    // command 3 is reserved and leaves everything alone.
    assign cmd_taken = i_ctrl_wr && (cmd != 2'd3);

    always_comb begin
        state_d      = state_q;
        o_timer_load = 1'b0;
        o_timer_len  = '0;

        if (cmd_taken) begin
            // every accepted command reloads the timer, so a window that is
            // cut short by halt or run leaves no count behind.
            o_timer_load = 1'b1;
            case (cmd)
                perf_pkg::CMD_HALT: begin
                    state_d = perf_pkg::ST_HALTED;
                end
                perf_pkg::CMD_RUN: begin
                    state_d = perf_pkg::ST_RUN;
                end
                default: begin
                    o_timer_len = win_len;
                    // an empty window halts at once.
                    state_d = (win_len == '0) ? perf_pkg::ST_HALTED : perf_pkg::ST_WINDOW;
                end
            endcase
        end else if ((state_q == perf_pkg::ST_WINDOW) && i_expire) begin
            state_d = perf_pkg::ST_HALTED;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= perf_pkg::ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_state    = state_q;
    assign o_count_en = (state_q == perf_pkg::ST_RUN) || (state_q == perf_pkg::ST_WINDOW);

    // the timer only runs out while a window is open.
    a_expire_in_window: assert property (
        @(posedge clk) disable iff (i_rst)
        i_expire |-> (state_q == perf_pkg::ST_WINDOW)
    ) else $error("perf_ctrl_fsm: i_expire outside window, state=%h", state_q);

endmodule

//--- hw/perf_window_timer.sv
`timescale 1ns/1ps
`include "perf_monitor_config.svh"

module perf_window_timer (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_load,
    input  logic [`PERF_WIN_W-1:0] i_len,
    output logic                   o_expire
);

    logic [`PERF_WIN_W-1:0] count_q;

    // load wins over the decrement; the count rests at zero.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            count_q <= '0;
        end else if (i_load) begin
            count_q <= i_len;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // last counting cycle of the window.
    assign o_expire = (count_q == `PERF_WIN_W'(1));

endmodule

//--- hw/perf_counter_bank.sv
`timescale 1ns/1ps
`include "perf_monitor_config.svh"

module perf_counter_bank (
    input  logic                    clk,
    input  logic                    i_rst,
    input  perf_pkg::perf_events_t  i_events,
    input  logic                    i_count_en,
    input  logic                    i_clr_valid,
    input  logic [`PERF_IDX_W-1:0]  i_clr_idx,
    input  logic                    i_rd_valid,
    input  logic [`PERF_IDX_W-1:0]  i_rd_idx,
    output logic [`PERF_DATA_W-1:0] o_rd_data
);

    logic [`PERF_NUM_CNT-1:0] ev_bits;
    logic [`PERF_DATA_W-1:0]  cnt_q [`PERF_NUM_CNT];

    // flatten the event struct so bit i feeds counter i.
    assign ev_bits[0]  = i_events.pred_correct;
    assign ev_bits[1]  = i_events.pred_incorrect;
    assign ev_bits[2]  = i_events.icache_hit;
    assign ev_bits[3]  = i_events.icache_miss;
    assign ev_bits[4]  = i_events.dcache_hit;
    assign ev_bits[5]  = i_events.dcache_miss;
    assign ev_bits[6]  = i_events.l2_hit;
    assign ev_bits[7]  = i_events.l2_miss;
    assign ev_bits[8]  = i_events.stall_if;
    assign ev_bits[9]  = i_events.stall_id;
    assign ev_bits[10] = i_events.stall_ex;
    assign ev_bits[11] = i_events.stall_mem;
    assign ev_bits[12] = i_events.stall_wb;

    // a clear beats an event to the same counter; counters wrap.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `PERF_NUM_CNT; i++) begin
            if (i_rst) begin
                cnt_q[i] <= '0;
            end else if (i_clr_valid && (i_clr_idx == `PERF_IDX_W'(i))) begin
                cnt_q[i] <= '0;
            end else if (i_count_en && ev_bits[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    // read mux that gives zero when nothing is selected.
    always_comb begin
        o_rd_data = '0;
        for (int i = 0; i < `PERF_NUM_CNT; i++) begin
            if (i_rd_valid && (i_rd_idx == `PERF_IDX_W'(i))) begin
                o_rd_data = cnt_q[i];
            end
        end
    end

    // the decoder must never hand over a clear for a missing counter.
    a_clr_idx_range: assert property (
        @(posedge clk) disable iff (i_rst)
        i_clr_valid |-> (i_clr_idx < `PERF_IDX_W'(`PERF_NUM_CNT))
    ) else $error("perf_counter_bank: clear index out of range, i_clr_idx=%h", i_clr_idx);

endmodule

//--- hw/perf_monitor.sv
`timescale 1ns/1ps
`include "perf_monitor_config.svh"

module perf_monitor (
    input  logic                    clk,
    input  logic                    i_rst,
    input  perf_pkg::perf_bus_req_t i_req,
    input  perf_pkg::perf_events_t  i_events,
    output logic                    o_access_cancel,
    output logic [`PERF_DATA_W-1:0] o_rdata
);

    perf_pkg::perf_decode_t  dec;
    perf_pkg::perf_state_e   state;
    logic                    count_en;
    logic                    timer_load;
    logic [`PERF_WIN_W-1:0]  timer_len;
    logic                    timer_expire;
    logic [`PERF_DATA_W-1:0] cnt_rd_data;
    logic [`PERF_DATA_W-1:0] ctrl_rd_data;

    perf_addr_decode u_decode (
        .i_req (i_req),
        .o_dec (dec)
    );

    perf_ctrl_fsm u_ctrl_fsm (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_ctrl_wr    (dec.ctrl_wr),
        .i_wdata      (i_req.wdata),
        .i_expire     (timer_expire),
        .o_state      (state),
        .o_count_en   (count_en),
        .o_timer_load (timer_load),
        .o_timer_len  (timer_len)
    );

    perf_window_timer u_window_timer (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_load   (timer_load),
        .i_len    (timer_len),
        .o_expire (timer_expire)
    );

    perf_counter_bank u_counter_bank (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_events    (i_events),
        .i_count_en  (count_en),
        .i_clr_valid (dec.clr_valid),
        .i_clr_idx   (dec.clr_idx),
        .i_rd_valid  (dec.rd_valid),
        .i_rd_idx    (dec.rd_idx),
        .o_rd_data   (cnt_rd_data)
    );

    // status read with the state code in the low two bits.
    always_comb begin
        ctrl_rd_data = '0;
        if (dec.rd_ctrl) begin
            ctrl_rd_data[1:0] = state;
        end
    end

    // counter and control reads never select together.
    assign o_rdata         = cnt_rd_data | ctrl_rd_data;
    assign o_access_cancel = dec.hit;

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // reset drops just after an edge, like every other input.
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

//--- tb/tb_perf_monitor.sv
`timescale 1ns/1ps
`include "perf_monitor_config.svh"

module tb_perf_monitor;

    localparam int CLK_PERIOD  = 100;
    localparam int MAX_CYCLES  = 4000;
    localparam int WATCHDOG_NS = (MAX_CYCLES + 20) * CLK_PERIOD;
    localparam int RUN_CYCLES  = 1500;
    localparam int CLR_CYCLES  = 300;
    localparam int HOLD_CYCLES = 100;
    localparam int NUM_WINDOWS = 20;

    logic                    clk;
    logic                    rst;
    perf_pkg::perf_bus_req_t req;
    perf_pkg::perf_events_t  events;
    logic                    access_cancel;
    logic [`PERF_DATA_W-1:0] rdata;

    // reference model.
    logic [`PERF_DATA_W-1:0] m_cnt [`PERF_NUM_CNT];
    perf_pkg::perf_state_e   m_state;
    int                      m_win;

    int errors;
    int checks;

    tb_clock_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (2)
    ) u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    perf_monitor perf_monitor_i (
        .clk             (clk),
        .i_rst           (rst),
        .i_req           (req),
        .i_events        (events),
        .o_access_cancel (access_cancel),
        .o_rdata         (rdata)
    );

    function automatic logic [`PERF_ADDR_W-1:0] cnt_addr(input int idx);
        return `PERF_ADDR_W'(`PERF_CNT_BASE_ADDR + 2 * idx);
    endfunction

    // counter index behind an address or -1 when there is none.
    function automatic int addr_to_idx(input logic [`PERF_ADDR_W-1:0] addr);
        int off;
        off = int'(addr) - int'(`PERF_CNT_BASE_ADDR);
        if ((off < 0) || off[0] || ((off / 2) >= `PERF_NUM_CNT)) begin
            return -1;
        end
        return off / 2;
    endfunction

    function automatic perf_pkg::perf_bus_req_t make_read(input logic [15:0] addr);
        perf_pkg::perf_bus_req_t r;
        r.access = 1'b1;
        r.we     = 1'b0;
        r.addr   = addr;
        r.wdata  = 16'($urandom());
        return r;
    endfunction

    function automatic perf_pkg::perf_bus_req_t make_write(input logic [15:0] addr,
                                                           input logic [15:0] data);
        perf_pkg::perf_bus_req_t r;
        r.access = 1'b1;
        r.we     = 1'b1;
        r.addr   = addr;
        r.wdata  = data;
        return r;
    endfunction

    // no access, but the other fields still move.
    function automatic perf_pkg::perf_bus_req_t idle_req();
        perf_pkg::perf_bus_req_t r;
        r        = 34'($urandom());
        r.access = 1'b0;
        r.addr   = 16'($urandom());
        return r;
    endfunction

    // each pulse high about one cycle in three.
    function automatic perf_pkg::perf_events_t rand_events();
        logic [`PERF_NUM_CNT-1:0] bits;
        for (int i = 0; i < `PERF_NUM_CNT; i++) begin
            bits[i] = ($urandom_range(2, 0) == 0);
        end
        return bits;
    endfunction

    // random traffic that never writes the control register.
    function automatic perf_pkg::perf_bus_req_t rand_access(input bit with_clears);
        int kind;
        kind = $urandom_range(5, 0);
        case (kind)
            0: return idle_req();
            1: return make_read(cnt_addr($urandom_range(12, 0)));
            2: return make_read(16'($urandom_range(32'hFFE3, 0)));
            3: return make_write(16'($urandom_range(32'hFFE3, 0)), 16'($urandom()));
            4: return make_read(16'($urandom_range(32'hFFFF, 32'hFFE4)));
            default: begin
                if (with_clears) begin
                    return make_write(cnt_addr($urandom_range(12, 0)), 16'($urandom()));
                end
                return make_read(cnt_addr($urandom_range(12, 0)));
            end
        endcase
    endfunction

    function automatic logic [`PERF_DATA_W-1:0] expect_rdata(input perf_pkg::perf_bus_req_t r);
        logic [`PERF_DATA_W-1:0] val;
        int                      idx;
        val = '0;
        idx = addr_to_idx(r.addr);
        if (r.access && !r.we) begin
            if (r.addr == `PERF_BASE_ADDR) begin
                val = {14'd0, m_state};
            end else if (idx >= 0) begin
                val = m_cnt[idx];
            end
        end
        return val;
    endfunction

    // what the next rising edge does to counters, state and window.
    task automatic model_step();
        logic [`PERF_NUM_CNT-1:0] ev_vec;
        logic [1:0]               cmd;
        logic                     en;
        int                       clr_idx;
        int                       len;
        // first struct field is the top bit and belongs to counter 0.
        ev_vec  = events;
        en      = (m_state == perf_pkg::ST_RUN) || (m_state == perf_pkg::ST_WINDOW);
        clr_idx = (req.access && req.we) ? addr_to_idx(req.addr) : -1;
        cmd     = req.wdata[1:0];
        len     = int'(req.wdata[15:2]);
        for (int i = 0; i < `PERF_NUM_CNT; i++) begin
            if (clr_idx == i) begin
                m_cnt[i] = '0;
            end else if (en && ev_vec[`PERF_NUM_CNT-1-i]) begin
                m_cnt[i] = m_cnt[i] + 16'd1;
            end
        end
        if (req.access && req.we && (req.addr == `PERF_BASE_ADDR) && (cmd != 2'd3)) begin
            m_win = 0;
            if (cmd == 2'd0) begin
                m_state = perf_pkg::ST_HALTED;
            end else if (cmd == 2'd1) begin
                m_state = perf_pkg::ST_RUN;
            end else begin
                m_win   = len;
                m_state = (len == 0) ? perf_pkg::ST_HALTED : perf_pkg::ST_WINDOW;
            end
        end else if (m_win != 0) begin
            if ((m_state == perf_pkg::ST_WINDOW) && (m_win == 1)) begin
                m_state = perf_pkg::ST_HALTED;
            end
            m_win = m_win - 1;
        end
    endtask

    // drives one cycle, checks the combinational outputs and advances the model.
    task automatic apply_cycle(input perf_pkg::perf_bus_req_t r,
                               input perf_pkg::perf_events_t  ev);
        logic [`PERF_DATA_W-1:0] exp_rdata;
        logic                    exp_cancel;
        @(posedge clk);
        #1;
        req    = r;
        events = ev;
        #1;
        exp_cancel = r.access && (r.addr >= `PERF_BASE_ADDR);
        exp_rdata  = expect_rdata(r);
        checks++;
        if (access_cancel !== exp_cancel) begin
            errors++;
            $display("Error: o_access_cancel addr=%h expected %h got %h",
                     r.addr, exp_cancel, access_cancel);
        end
        checks++;
        if (rdata !== exp_rdata) begin
            errors++;
            $display("Error: o_rdata addr=%h expected %h got %h", r.addr, exp_rdata, rdata);
        end
        model_step();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [`PERF_DATA_W-1:0] snap [`PERF_NUM_CNT];
        logic [`PERF_DATA_W-1:0] gain;
        perf_pkg::perf_events_t  all_ev;
        int                      seed_ret;
        int                      len;
        int                      k;
        seed_ret = $urandom(32'h4eb5_8da0);
        req      = '0;
        events   = '0;
        all_ev   = '1;
        errors   = 0;
        checks   = 0;
        m_state  = perf_pkg::ST_RUN;
        m_win    = 0;
        for (int i = 0; i < `PERF_NUM_CNT; i++) begin
            m_cnt[i] = '0;
        end
        wait (rst == 1'b0);

        // reset values while no events arrive.
        for (int i = 0; i < `PERF_NUM_CNT; i++) begin
            apply_cycle(make_read(cnt_addr(i)), '0);
        end
        apply_cycle(make_read(`PERF_BASE_ADDR), '0);
        apply_cycle(make_read(16'h3000), '0);

        // free running with reads all over the address space.
        for (int c = 0; c < RUN_CYCLES; c++) begin
            apply_cycle(rand_access(1'b0), rand_events());
        end

        // a clear beats an event to the same counter.
        for (int c = 0; c < 30; c++) begin
            k = $urandom_range(12, 0);
            apply_cycle(make_write(cnt_addr(k), 16'($urandom())), all_ev);
            apply_cycle(make_read(cnt_addr(k)), rand_events());
            checks++;
            if (rdata !== '0) begin
                errors++;
                $display("Error: o_rdata counter %0d after clear expected %h got %h",
                         k, 16'h0000, rdata);
            end
        end
        for (int c = 0; c < CLR_CYCLES; c++) begin
            apply_cycle(rand_access(1'b1), rand_events());
        end

        // halt, a reserved command, then run again.
        apply_cycle(make_write(`PERF_BASE_ADDR, 16'h0000), rand_events());
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            apply_cycle(rand_access(1'b0), rand_events());
        end
        apply_cycle(make_write(`PERF_BASE_ADDR, 16'h0003), rand_events());
        apply_cycle(make_read(`PERF_BASE_ADDR), rand_events());
        checks++;
        if (rdata !== {14'd0, perf_pkg::ST_HALTED}) begin
            errors++;
            $display("Error: o_rdata control after halt expected %h got %h",
                     {14'd0, perf_pkg::ST_HALTED}, rdata);
        end
        apply_cycle(make_write(`PERF_BASE_ADDR, 16'h0001), rand_events());
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            apply_cycle(rand_access(1'b0), rand_events());
        end

        // counting windows that start from the halted state.
        apply_cycle(make_write(`PERF_BASE_ADDR, 16'h0000), rand_events());
        for (int w = 0; w < NUM_WINDOWS; w++) begin
            len  = (w == 0) ? 0 : int'($urandom_range(40, 0));
            snap = m_cnt;
            apply_cycle(make_write(`PERF_BASE_ADDR, {14'(len), 2'b10}), rand_events());
            for (int c = 0; c < len; c++) begin
                apply_cycle(rand_access(1'b0), rand_events());
            end
            apply_cycle(make_read(`PERF_BASE_ADDR), rand_events());
            checks++;
            if (rdata !== {14'd0, perf_pkg::ST_HALTED}) begin
                errors++;
                $display("Error: o_rdata control after window of %h expected %h got %h",
                         len, {14'd0, perf_pkg::ST_HALTED}, rdata);
            end
            for (int i = 0; i < `PERF_NUM_CNT; i++) begin
                apply_cycle(make_read(cnt_addr(i)), rand_events());
                gain = rdata - snap[i];
                checks++;
                if (gain > 16'(len)) begin
                    errors++;
                    $display("Error: o_rdata counter %0d gained %h in a window of %h",
                             i, gain, len);
                end
            end
        end

        // odd addresses in the window are cancelled and read as zero.
        apply_cycle(make_write(`PERF_BASE_ADDR, 16'h0001), rand_events());
        for (int a = 'hFFE4; a <= 'hFFFF; a++) begin
            if (a[0]) begin
                apply_cycle(make_write(16'(a), 16'($urandom())), rand_events());
            end
            apply_cycle(make_read(16'(a)), rand_events());
        end

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- perf_monitor.f
+incdir+hw
hw/perf_pkg.sv
hw/perf_addr_decode.sv
hw/perf_ctrl_fsm.sv
hw/perf_window_timer.sv
hw/perf_counter_bank.sv
hw/perf_monitor.sv
tb/tb_clock_gen.sv
tb/tb_perf_monitor.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f perf_monitor.f \
    --top-module tb_perf_monitor \
    -o sim_perf_monitor

./obj_dir/sim_perf_monitor | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a pass result"
    exit 1
fi

echo "simulation passed"
